//--- gbcore.f
+incdir+.
gbcore_pkg.sv
gbcore_decoder.sv
gbcore_alu.sv
gbcore_idu.sv
gbcore_cpu.sv
gbcore_top.sv
tb_gbcore.sv

//--- gbcore_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "gbcore_config.svh"

module gbcore_alu (
  input  logic [3:0] alu_op,
  input  logic [7:0] a,
  input  logic [7:0] b,
  input  logic       carry_in,
  output logic [7:0] result,
  output logic [7:0] flags,
  output logic       write_result
);

  logic [8:0] full;
  logic [4:0] half;
  logic       cin;

  always_comb begin
    cin          = (alu_op == `GB_ALU_ADC || alu_op == `GB_ALU_SBC) ? carry_in : 1'b0;
    full         = '0;
    half         = '0;
    result       = b;
    flags        = '0;
    write_result = 1'b1;

    case (alu_op)
      `GB_ALU_ADD, `GB_ALU_ADC: begin
        full   = {1'b0, a} + {1'b0, b} + {8'd0, cin};
        half   = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, cin};
        result = full[7:0];
        flags[`GB_FLAG_H] = half[4];
        flags[`GB_FLAG_C] = full[8];
      end
      `GB_ALU_SUB, `GB_ALU_SBC, `GB_ALU_CP: begin
        full   = {1'b0, a} - {1'b0, b} - {8'd0, cin};
        half   = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'd0, cin};
        result = full[7:0];
        flags[`GB_FLAG_N] = 1'b1;
        flags[`GB_FLAG_H] = half[4];  // Borrow out of bit 3
        flags[`GB_FLAG_C] = full[8];
        write_result = (alu_op != `GB_ALU_CP);  // CP sets flags only
      end
      `GB_ALU_AND: begin
        result = a & b;
        flags[`GB_FLAG_H] = 1'b1;
      end
      `GB_ALU_XOR: result = a ^ b;
      `GB_ALU_OR:  result = a | b;
      `GB_ALU_INC: begin
        result = b + 8'd1;
        flags[`GB_FLAG_H] = (b[3:0] == 4'hF);
        flags[`GB_FLAG_C] = carry_in;
      end
      `GB_ALU_DEC: begin
        result = b - 8'd1;
        flags[`GB_FLAG_N] = 1'b1;
        flags[`GB_FLAG_H] = (b[3:0] == 4'h0);
        flags[`GB_FLAG_C] = carry_in;
      end
      default: result = b;  // PASS, flags ignored by the sequencer
    endcase

    flags[`GB_FLAG_Z] = (result == 8'h00);
  end

endmodule

`default_nettype wire

//--- gbcore_config.svh
`ifndef GBCORE_CONFIG_SVH
`define GBCORE_CONFIG_SVH

// T-phases of one M-cycle
`define GB_T1 2'd0
`define GB_T2 2'd1
`define GB_T3 2'd2
`define GB_T4 2'd3

// Address source for T1
`define GB_ADDR_PC   2'd0
`define GB_ADDR_HL   2'd1
`define GB_ADDR_NONE 2'd2

`define GB_BUS_NONE  2'd0
`define GB_BUS_READ  2'd1
`define GB_BUS_WRITE 2'd2

// Byte register selectors, SM83 order first
`define GB_R_B    4'd0
`define GB_R_C    4'd1
`define GB_R_D    4'd2
`define GB_R_E    4'd3
`define GB_R_H    4'd4
`define GB_R_L    4'd5
`define GB_R_MHL  4'd6
`define GB_R_A    4'd7
`define GB_R_Z    4'd8
`define GB_R_W    4'd9
`define GB_R_SPL  4'd10
`define GB_R_SPH  4'd11
`define GB_R_NONE 4'd15

// ALU ops 0..7 follow the y field of the opcode
`define GB_ALU_ADD  4'd0
`define GB_ALU_ADC  4'd1
`define GB_ALU_SUB  4'd2
`define GB_ALU_SBC  4'd3
`define GB_ALU_AND  4'd4
`define GB_ALU_XOR  4'd5
`define GB_ALU_OR   4'd6
`define GB_ALU_CP   4'd7
`define GB_ALU_INC  4'd8
`define GB_ALU_DEC  4'd9
`define GB_ALU_PASS 4'd10

`define GB_IDU_NONE 2'd0
`define GB_IDU_INC  2'd1
`define GB_IDU_DEC  2'd2

// 16-bit targets of the IDU, BC..SP match the p field
`define GB_PAIR_BC   3'd0
`define GB_PAIR_DE   3'd1
`define GB_PAIR_HL   3'd2
`define GB_PAIR_SP   3'd3
`define GB_PAIR_PC   3'd4
`define GB_PAIR_NONE 3'd7

`define GB_FLAG_Z 7
`define GB_FLAG_N 6
`define GB_FLAG_H 5
`define GB_FLAG_C 4

`define GB_PC_RESET 16'h0000
`define GB_SP_RESET 16'hFFFE

`define GB_MAX_MCYCLES 4
`define GB_OP_HALT     8'h76

`endif

//--- gbcore_cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "gbcore_config.svh"

module gbcore_cpu import gbcore_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic [7:0]  rdata,
  input  logic [1:0]  addr_src,
  input  logic [1:0]  bus_op,
  input  logic [3:0]  bus_reg,
  input  logic [3:0]  alu_op,
  input  logic [3:0]  alu_dst,
  input  logic [1:0]  idu_op,
  input  logic [2:0]  idu_pair,
  input  logic        cond_check,
  input  logic [$clog2(`GB_MAX_MCYCLES)-1:0] last_mcycle,
  input  logic [7:0]  alu_result,
  input  logic [7:0]  alu_flags,
  input  logic        alu_write,
  input  logic [15:0] idu_result,
  output logic [15:0] addr_bus,
  output logic [7:0]  wdata,
  output logic        mem_read,
  output logic        mem_write,
  output logic        halted,
  output opcode_u     opcode,
  output logic [$clog2(`GB_MAX_MCYCLES)-1:0] mcycle,
  output logic [7:0]  alu_a,
  output logic [7:0]  alu_b,
  output logic        alu_carry,
  output logic [15:0] idu_operand
);

  logic [1:0]  t_phase;
  logic [7:0]  gpr [0:7];  // B C D E H L - A
  logic [7:0]  flags;
  logic [7:0]  z_latch;
  logic [7:0]  w_latch;
  logic [15:0] sp;
  logic [15:0] pc;
  logic [7:0]  sel_data;  // Byte named by bus_reg
  logic        wr_en;
  logic [3:0]  wr_sel;
  logic [7:0]  wr_data;

  always_comb begin
    case (bus_reg)
      `GB_R_Z:   sel_data = z_latch;
      `GB_R_W:   sel_data = w_latch;
      `GB_R_SPL: sel_data = sp[7:0];
      `GB_R_SPH: sel_data = sp[15:8];
      default:   sel_data = gpr[bus_reg[2:0]];
    endcase
  end

  assign alu_a     = gpr[3'(`GB_R_A)];
  assign alu_b     = sel_data;
  assign alu_carry = flags[`GB_FLAG_C];

  // No IDU op means the WZ latches move into the pair
  always_comb begin
    if (idu_op == `GB_IDU_NONE) begin
      idu_operand = {w_latch, z_latch};
    end else begin
      case (idu_pair)
        `GB_PAIR_BC: idu_operand = {gpr[3'(`GB_R_B)], gpr[3'(`GB_R_C)]};
        `GB_PAIR_DE: idu_operand = {gpr[3'(`GB_R_D)], gpr[3'(`GB_R_E)]};
        `GB_PAIR_HL: idu_operand = {gpr[3'(`GB_R_H)], gpr[3'(`GB_R_L)]};
        `GB_PAIR_SP: idu_operand = sp;
        default:     idu_operand = pc;
      endcase
    end
  end

  // One byte write port, bus loads in T3 and ALU results in T4
  always_comb begin
    wr_en   = 1'b0;
    wr_sel  = bus_reg;
    wr_data = rdata;
    if (t_phase == `GB_T3 && bus_op == `GB_BUS_READ && mcycle != '0) begin
      wr_en = 1'b1;
    end else if (t_phase == `GB_T4 && alu_write && alu_dst != `GB_R_NONE) begin
      wr_en   = 1'b1;
      wr_sel  = alu_dst;
      wr_data = alu_result;
    end
  end

  always_ff @(posedge clk) begin
    if (t_phase == `GB_T2 && bus_op == `GB_BUS_WRITE)
      wdata <= sel_data;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      t_phase    <= `GB_T1;
      mcycle     <= '0;
      addr_bus   <= `GB_PC_RESET;
      mem_read   <= 1'b0;
      mem_write  <= 1'b0;
      halted     <= 1'b0;
      opcode.raw <= 8'h00;  // Decodes as NOP
      pc         <= `GB_PC_RESET;
      sp         <= `GB_SP_RESET;
      flags      <= 8'h00;
      z_latch    <= 8'h00;
      w_latch    <= 8'h00;
      for (int i = 0; i < 8; i++)
        gpr[i] <= 8'h00;
    end else if (!halted) begin
      case (t_phase)
        `GB_T1: begin
          if (addr_src == `GB_ADDR_PC)
            addr_bus <= pc;
          else if (addr_src == `GB_ADDR_HL)
            addr_bus <= {gpr[3'(`GB_R_H)], gpr[3'(`GB_R_L)]};
          t_phase <= `GB_T2;
        end
        `GB_T2: begin
          mem_read  <= (bus_op == `GB_BUS_READ);
          mem_write <= (bus_op == `GB_BUS_WRITE);
          t_phase   <= `GB_T3;
        end
        `GB_T3: begin
          if (mcycle == '0)
            opcode.raw <= rdata;  // Fetch fills the opcode latch
          t_phase <= `GB_T4;
        end
        default: begin
          mem_read  <= 1'b0;
          mem_write <= 1'b0;
          if (alu_op != `GB_ALU_PASS)
            flags <= alu_flags;
          case (idu_pair)
            `GB_PAIR_BC: {gpr[3'(`GB_R_B)], gpr[3'(`GB_R_C)]} <= idu_result;
            `GB_PAIR_DE: {gpr[3'(`GB_R_D)], gpr[3'(`GB_R_E)]} <= idu_result;
            `GB_PAIR_HL: {gpr[3'(`GB_R_H)], gpr[3'(`GB_R_L)]} <= idu_result;
            `GB_PAIR_SP: sp <= idu_result;
            `GB_PAIR_PC: pc <= idu_result;
            default: ;
          endcase
          if (mcycle == '0 && opcode.raw == `GB_OP_HALT)
            halted <= 1'b1;
          else if (cond_check && !cond_met(opcode.f.y[1:0], flags))
            mcycle <= '0;  // Untaken JP cc ends here
          else if (mcycle == last_mcycle)
            mcycle <= '0;
          else
            mcycle <= mcycle + 1'b1;
          t_phase <= `GB_T1;
        end
      endcase

      if (wr_en) begin
        case (wr_sel)
          `GB_R_Z:   z_latch  <= wr_data;
          `GB_R_W:   w_latch  <= wr_data;
          `GB_R_SPL: sp[7:0]  <= wr_data;
          `GB_R_SPH: sp[15:8] <= wr_data;
          default:   gpr[wr_sel[2:0]] <= wr_data;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- gbcore_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "gbcore_config.svh"

module gbcore_decoder import gbcore_pkg::*; (
  input  opcode_u    opcode,
  input  logic [1:0] mcycle,
  output logic [1:0] addr_src,
  output logic [1:0] bus_op,
  output logic [3:0] bus_reg,
  output logic [3:0] alu_op,
  output logic [3:0] alu_dst,
  output logic [1:0] idu_op,
  output logic [2:0] idu_pair,
  output logic       cond_check,
  output logic [1:0] last_mcycle
);

  logic [2:0] y;
  logic [2:0] z;
  logic       y_is_mem;  // y names (HL)
  logic       z_is_mem;

  assign y = opcode.f.y;
  assign z = opcode.f.z;
  assign y_is_mem = ({1'b0, y} == `GB_R_MHL);
  assign z_is_mem = ({1'b0, z} == `GB_R_MHL);

  always_comb begin
    addr_src    = `GB_ADDR_NONE;
    bus_op      = `GB_BUS_NONE;
    bus_reg     = `GB_R_NONE;
    alu_op      = `GB_ALU_PASS;
    alu_dst     = `GB_R_NONE;
    idu_op      = `GB_IDU_NONE;
    idu_pair    = `GB_PAIR_NONE;
    cond_check  = 1'b0;
    last_mcycle = 2'd0;

    // Fetch cycle is the same for every opcode
    if (mcycle == 2'd0) begin
      addr_src = `GB_ADDR_PC;
      bus_op   = `GB_BUS_READ;
      idu_op   = `GB_IDU_INC;
      idu_pair = `GB_PAIR_PC;
    end

    case (opcode.f.x)
      2'b00: begin
        case (z)
          3'd1: if (!y[0]) begin  // LD rr,d16
            last_mcycle = 2'd2;
            if (mcycle != 2'd0) begin
              addr_src = `GB_ADDR_PC;
              bus_op   = `GB_BUS_READ;
              idu_op   = `GB_IDU_INC;
              idu_pair = `GB_PAIR_PC;
              if (y[2:1] == 2'd3)
                bus_reg = (mcycle == 2'd1) ? `GB_R_SPL : `GB_R_SPH;
              else
                bus_reg = {1'b0, y[2:1], (mcycle == 2'd1)};  // Low byte first
            end
          end
          3'd3: begin  // INC rr / DEC rr
            last_mcycle = 2'd1;
            if (mcycle == 2'd1) begin
              idu_op   = y[0] ? `GB_IDU_DEC : `GB_IDU_INC;
              idu_pair = {1'b0, y[2:1]};
            end
          end
          3'd4, 3'd5: if (!y_is_mem) begin
            bus_reg = {1'b0, y};  // Operand goes in on b
            alu_op  = (z == 3'd4) ? `GB_ALU_INC : `GB_ALU_DEC;
            alu_dst = {1'b0, y};
          end
          3'd6: begin
            last_mcycle = y_is_mem ? 2'd2 : 2'd1;
            if (mcycle == 2'd1) begin
              addr_src = `GB_ADDR_PC;
              bus_op   = `GB_BUS_READ;
              idu_op   = `GB_IDU_INC;
              idu_pair = `GB_PAIR_PC;
              bus_reg  = y_is_mem ? `GB_R_Z : {1'b0, y};
            end else if (mcycle == 2'd2) begin
              addr_src = `GB_ADDR_HL;  // LD (HL),d8 store
              bus_op   = `GB_BUS_WRITE;
              bus_reg  = `GB_R_Z;
            end
          end
          default: ;
        endcase
      end
      2'b01: begin
        if (y_is_mem && z_is_mem) begin
          last_mcycle = 2'd0;  // HALT, the sequencer stops on it
        end else if (z_is_mem || y_is_mem) begin
          last_mcycle = 2'd1;
          if (mcycle == 2'd1) begin
            addr_src = `GB_ADDR_HL;
            bus_op   = z_is_mem ? `GB_BUS_READ : `GB_BUS_WRITE;
            bus_reg  = z_is_mem ? {1'b0, y} : {1'b0, z};
          end
        end else begin
          bus_reg = {1'b0, z};
          alu_dst = {1'b0, y};
        end
      end
      2'b10: begin
        if (z_is_mem) begin
          last_mcycle = 2'd1;
          if (mcycle == 2'd1) begin
            addr_src = `GB_ADDR_HL;
            bus_op   = `GB_BUS_READ;
            bus_reg  = `GB_R_Z;
            alu_op   = {1'b0, y};
            alu_dst  = `GB_R_A;
          end
        end else begin
          bus_reg = {1'b0, z};
          alu_op  = {1'b0, y};
          alu_dst = `GB_R_A;
        end
      end
      default: begin
        if (z_is_mem) begin  // ALU A,d8
          last_mcycle = 2'd1;
          if (mcycle == 2'd1) begin
            addr_src = `GB_ADDR_PC;
            bus_op   = `GB_BUS_READ;
            idu_op   = `GB_IDU_INC;
            idu_pair = `GB_PAIR_PC;
            bus_reg  = `GB_R_Z;
            alu_op   = {1'b0, y};
            alu_dst  = `GB_R_A;
          end
        end else if ((z == 3'd3 && y == 3'd0) || (z == 3'd2 && !y[2])) begin
          last_mcycle = 2'd3;
          if (mcycle == 2'd1 || mcycle == 2'd2) begin
            addr_src   = `GB_ADDR_PC;
            bus_op     = `GB_BUS_READ;
            idu_op     = `GB_IDU_INC;
            idu_pair   = `GB_PAIR_PC;
            bus_reg    = (mcycle == 2'd1) ? `GB_R_Z : `GB_R_W;
            cond_check = (mcycle == 2'd2) && (z == 3'd2);
          end else if (mcycle == 2'd3) begin
            idu_pair = `GB_PAIR_PC;  // PC takes WZ
          end
        end
      end
    endcase
  end

endmodule

`default_nettype wire

//--- gbcore_idu.sv
`timescale 1ns/1ps
`default_nettype none

`include "gbcore_config.svh"

module gbcore_idu (
  input  logic [1:0]  idu_op,
  input  logic [15:0] operand,
  output logic [15:0] result
);

  // Runs beside the ALU in T4, wraps at 16 bits
  always_comb begin
    case (idu_op)
      `GB_IDU_INC: result = operand + 16'd1;
      `GB_IDU_DEC: result = operand - 16'd1;
      default:     result = operand;  // Plain transfer, as for JP
    endcase
  end

endmodule

`default_nettype wire

//--- gbcore_pkg.sv
`default_nettype none

package gbcore_pkg;

  `include "gbcore_config.svh"

  // x/y/z split used by the decoder
  typedef struct packed {
    logic [1:0] x;
    logic [2:0] y;
    logic [2:0] z;
  } opcode_fields_t;

  typedef union packed {
    logic [7:0]     raw;
    opcode_fields_t f;
  } opcode_u;

  // cc 0..3 is NZ, Z, NC, C
  function automatic logic cond_met(input logic [1:0] cc, input logic [7:0] flags);
    logic met;
    case (cc)
      2'd0:    met = !flags[`GB_FLAG_Z];
      2'd1:    met = flags[`GB_FLAG_Z];
      2'd2:    met = !flags[`GB_FLAG_C];
      default: met = flags[`GB_FLAG_C];
    endcase
    return met;
  endfunction

endpackage

`default_nettype wire

//--- gbcore_top.sv
`timescale 1ns/1ps
`default_nettype none

module gbcore_top import gbcore_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic [7:0]  rdata,
  output logic [15:0] addr_bus,
  output logic [7:0]  wdata,
  output logic        mem_read,
  output logic        mem_write,
  output logic        halted
);

  opcode_u     opcode;
  logic [1:0]  mcycle;
  logic [1:0]  addr_src;
  logic [1:0]  bus_op;
  logic [3:0]  bus_reg;
  logic [3:0]  alu_op;
  logic [3:0]  alu_dst;
  logic [1:0]  idu_op;
  logic [2:0]  idu_pair;
  logic        cond_check;
  logic [1:0]  last_mcycle;
  logic [7:0]  alu_a;
  logic [7:0]  alu_b;
  logic        alu_carry;
  logic [7:0]  alu_result;
  logic [7:0]  alu_flags;
  logic        alu_write;
  logic [15:0] idu_operand;
  logic [15:0] idu_result;

  gbcore_decoder decoder0 (
    .opcode      (opcode),
    .mcycle      (mcycle),
    .addr_src    (addr_src),
    .bus_op      (bus_op),
    .bus_reg     (bus_reg),
    .alu_op      (alu_op),
    .alu_dst     (alu_dst),
    .idu_op      (idu_op),
    .idu_pair    (idu_pair),
    .cond_check  (cond_check),
    .last_mcycle (last_mcycle)
  );

  gbcore_alu alu0 (
    .alu_op       (alu_op),
    .a            (alu_a),
    .b            (alu_b),
    .carry_in     (alu_carry),
    .result       (alu_result),
    .flags        (alu_flags),
    .write_result (alu_write)
  );

  gbcore_idu idu0 (
    .idu_op  (idu_op),
    .operand (idu_operand),
    .result  (idu_result)
  );

  gbcore_cpu cpu0 (
    .clk         (clk),
    .reset       (reset),
    .rdata       (rdata),
    .addr_src    (addr_src),
    .bus_op      (bus_op),
    .bus_reg     (bus_reg),
    .alu_op      (alu_op),
    .alu_dst     (alu_dst),
    .idu_op      (idu_op),
    .idu_pair    (idu_pair),
    .cond_check  (cond_check),
    .last_mcycle (last_mcycle),
    .alu_result  (alu_result),
    .alu_flags   (alu_flags),
    .alu_write   (alu_write),
    .idu_result  (idu_result),
    .addr_bus    (addr_bus),
    .wdata       (wdata),
    .mem_read    (mem_read),
    .mem_write   (mem_write),
    .halted      (halted),
    .opcode      (opcode),
    .mcycle      (mcycle),
    .alu_a       (alu_a),
    .alu_b       (alu_b),
    .alu_carry   (alu_carry),
    .idu_operand (idu_operand)
  );

endmodule

`default_nettype wire

//--- run_gbcore.sh
#!/bin/sh
# Build with Verilator, run, then judge the log
rm -f sim_gbcore.log
verilator --binary --timing -Wno-fatal --top-module tb_gbcore -f gbcore.f -o sim_gbcore \
  && ./obj_dir/sim_gbcore > sim_gbcore.log 2>&1 \
  || { echo "Build or run error"; exit 1; }
cat sim_gbcore.log
[ -f sim_gbcore.log ] || exit 1
grep -q "Test failed" sim_gbcore.log && exit 1 || exit 0

//--- tb_gbcore_model.svh
`ifndef TB_GBCORE_MODEL_SVH
`define TB_GBCORE_MODEL_SVH

// Reference interpreter state, separate from the DUT memory
logic [7:0]  mm [0:65535];
logic [7:0]  mr [0:7];  // B C D E H L - A
logic [7:0]  mf;        // Z N H C in bits 7..4
logic [15:0] msp;
logic [15:0] mpc;
int          exp_pc [$];      // Address of each fetch
int          exp_cycles [$];  // M-cycles of each instruction
int          exp_waddr [$];
int          exp_wdata [$];

function automatic logic [15:0] pair_get(input logic [1:0] p);
  case (p)
    2'd0:    return {mr[0], mr[1]};
    2'd1:    return {mr[2], mr[3]};
    2'd2:    return {mr[4], mr[5]};
    default: return msp;
  endcase
endfunction

task automatic pair_set(input logic [1:0] p, input logic [15:0] v);
  case (p)
    2'd0:    {mr[0], mr[1]} = v;
    2'd1:    {mr[2], mr[3]} = v;
    2'd2:    {mr[4], mr[5]} = v;
    default: msp = v;
  endcase
endtask

task automatic fetch_imm(output logic [7:0] b);
  b = mm[mpc];
  mpc = mpc + 16'd1;
endtask

task automatic model_write(input logic [15:0] a, input logic [7:0] d);
  mm[a] = d;
  exp_waddr.push_back(int'(a));
  exp_wdata.push_back(int'(d));
endtask

// NZ Z NC C
function automatic bit cond_true(input logic [1:0] cc);
  case (cc)
    2'd0:    return !mf[7];
    2'd1:    return mf[7];
    2'd2:    return !mf[4];
    default: return mf[4];
  endcase
endfunction

task automatic model_alu(input logic [2:0] op, input logic [7:0] v);
  logic [7:0] a;
  logic [7:0] res;
  logic       cin;
  logic       h;
  logic       c;
  a   = mr[7];
  cin = (op == 3'd1 || op == 3'd3) ? mf[4] : 1'b0;
  case (op)
    3'd0, 3'd1: begin
      res = a + v + {7'd0, cin};
      c   = (int'(a) + int'(v) + int'(cin)) > 255;
      h   = (int'(a[3:0]) + int'(v[3:0]) + int'(cin)) > 15;
      mf  = {res == 8'h00, 1'b0, h, c, 4'h0};
    end
    3'd2, 3'd3, 3'd7: begin
      res = a - v - {7'd0, cin};
      c   = int'(a) < int'(v) + int'(cin);  // Borrow
      h   = int'(a[3:0]) < int'(v[3:0]) + int'(cin);
      mf  = {res == 8'h00, 1'b1, h, c, 4'h0};
    end
    3'd4: begin
      res = a & v;
      mf  = {res == 8'h00, 3'b010, 4'h0};
    end
    3'd5: begin
      res = a ^ v;
      mf  = {res == 8'h00, 7'd0};
    end
    default: begin
      res = a | v;
      mf  = {res == 8'h00, 7'd0};
    end
  endcase
  if (op != 3'd7)
    mr[7] = res;  // CP leaves A alone
endtask

task automatic model_incdec(input logic [2:0] r, input logic dec);
  logic [7:0] v;
  v = mr[r];
  if (dec) begin
    mr[r] = v - 8'd1;
    mf = {mr[r] == 8'h00, 1'b1, v[3:0] == 4'h0, mf[4], 4'h0};
  end else begin
    mr[r] = v + 8'd1;
    mf = {mr[r] == 8'h00, 1'b0, v[3:0] == 4'hF, mf[4], 4'h0};  // Carry kept
  end
endtask

task automatic model_run();
  logic [7:0]  op;
  logic [7:0]  lo;
  logic [7:0]  hi;
  logic [15:0] hl;
  int          cyc;
  bit          halt;
  int          steps;
  mpc = 16'h0000;
  msp = 16'hFFFE;
  mf  = 8'h00;
  for (int i = 0; i < 8; i++)
    mr[i] = 8'h00;
  halt  = 0;
  steps = 0;
  while (!halt && steps < 1000) begin
    exp_pc.push_back(int'(mpc));
    fetch_imm(op);
    hl  = {mr[4], mr[5]};
    cyc = 1;
    case (op[7:6])
      2'd0: begin
        if (op[2:0] == 3'd1 && !op[3]) begin  // LD rr,d16
          fetch_imm(lo);
          fetch_imm(hi);
          pair_set(op[5:4], {hi, lo});
          cyc = 3;
        end else if (op[2:0] == 3'd3) begin
          pair_set(op[5:4], op[3] ? pair_get(op[5:4]) - 16'd1 : pair_get(op[5:4]) + 16'd1);
          cyc = 2;
        end else if ((op[2:0] == 3'd4 || op[2:0] == 3'd5) && op[5:3] != 3'd6) begin
          model_incdec(op[5:3], op[0]);
        end else if (op[2:0] == 3'd6) begin
          fetch_imm(lo);
          if (op[5:3] == 3'd6) begin
            model_write(hl, lo);
            cyc = 3;
          end else begin
            mr[op[5:3]] = lo;
            cyc = 2;
          end
        end
      end
      2'd1: begin
        if (op == 8'h76) begin
          halt = 1;
        end else if (op[2:0] == 3'd6) begin
          mr[op[5:3]] = mm[hl];
          cyc = 2;
        end else if (op[5:3] == 3'd6) begin
          model_write(hl, mr[op[2:0]]);
          cyc = 2;
        end else begin
          mr[op[5:3]] = mr[op[2:0]];
        end
      end
      2'd2: begin
        if (op[2:0] == 3'd6) begin
          model_alu(op[5:3], mm[hl]);
          cyc = 2;
        end else begin
          model_alu(op[5:3], mr[op[2:0]]);
        end
      end
      default: begin
        if (op[2:0] == 3'd6) begin
          fetch_imm(lo);
          model_alu(op[5:3], lo);
          cyc = 2;
        end else if (op == 8'hC3 || (op[2:0] == 3'd2 && !op[5])) begin
          fetch_imm(lo);
          fetch_imm(hi);
          cyc = 3;
          if (op == 8'hC3 || cond_true(op[4:3])) begin
            mpc = {hi, lo};
            cyc = 4;
          end
        end
      end
    endcase
    exp_cycles.push_back(cyc);
    steps++;
  end
endtask

`endif

//--- tb_gbcore.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gbcore;

  logic        clk;
  logic        reset;
  logic [7:0]  rdata;
  logic [15:0] addr_bus;
  logic [7:0]  wdata;
  logic        mem_read;
  logic        mem_write;
  logic        halted;

  logic [7:0]  mem [0:65535];
  logic [15:0] lfsr;
  int          errors;
  int          cycle;
  int          next_fetch;  // -1 until the first fetch is seen
  int          fetch_idx;
  int          write_idx;
  int          strobe_len;
  logic [15:0] strobe_addr;
  logic        prev_read;
  logic        prev_write;

  `include "tb_gbcore_model.svh"

  gbcore_top dut0 (
    .clk       (clk),
    .reset     (reset),
    .rdata     (rdata),
    .addr_bus  (addr_bus),
    .wdata     (wdata),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .halted    (halted)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Zero-wait memory with addr_bus settled a clock before the sample edge
  always @(posedge clk)
    rdata <= mem[addr_bus];

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("Mismatch %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = (v << 1) | int'(lfsr[0]);
    end
  endtask

  // Keeps H and L untouched so (HL) stays in data space
  function automatic logic [2:0] safe_reg(input int r, input bit mem_ok);
    case (r)
      0, 1, 2, 3: return 3'(r);
      5:          return mem_ok ? 3'd6 : 3'd7;
      default:    return 3'd7;
    endcase
  endfunction

  task automatic build_program();
    int         pc;
    int         kind;
    int         a;
    int         b;
    int         d;
    int         t;
    int         k;
    int         tgt;
    logic [2:0] y;
    logic [1:0] p;
    int         starts [$];
    int         jump_at [$];
    int         jump_ins [$];
    for (int i = 0; i < 65536; i++)
      mem[i] = 8'(i >> 8) ^ 8'(i) ^ 8'h5A;
    mem[0] = 8'h21;  // LD HL,0xC080
    mem[1] = 8'h80;
    mem[2] = 8'hC0;
    pc = 3;
    while (pc < 252) begin
      starts.push_back(pc);
      rand_bits(3, kind);
      rand_bits(3, a);
      rand_bits(3, b);
      rand_bits(8, d);
      case (kind)
        0: begin  // LD r,d8
          mem[pc] = {2'b00, safe_reg(a, 1'b1), 3'd6};
          mem[pc + 1] = 8'(d);
          pc += 2;
        end
        1: begin
          y = safe_reg(a, 1'b1);
          mem[pc] = {2'b01, y, (y == 3'd6 && b == 6) ? 3'd7 : 3'(b)};  // Never HALT
          pc += 1;
        end
        2: begin
          mem[pc] = {2'b10, 3'(a), 3'(b)};
          pc += 1;
        end
        3: begin
          mem[pc] = {2'b11, 3'(a), 3'd6};
          mem[pc + 1] = 8'(d);
          pc += 2;
        end
        4: begin
          mem[pc] = {2'b00, safe_reg(a, 1'b0), 2'b10, b[0]};
          pc += 1;
        end
        5: begin  // LD rr,d16 without HL
          p = (a[1:0] == 2'd2) ? 2'd3 : a[1:0];
          rand_bits(8, t);
          mem[pc] = {2'b00, p, 4'b0001};
          mem[pc + 1] = 8'(d);
          mem[pc + 2] = 8'(t);
          pc += 3;
        end
        6: begin
          mem[pc] = {2'b00, a[1:0], b[0], 3'b011};
          pc += 1;
        end
        default: begin
          mem[pc] = b[2] ? 8'hC3 : {3'b110, a[1:0], 3'b010};
          jump_at.push_back(pc + 1);
          jump_ins.push_back(starts.size() - 1);
          pc += 3;
        end
      endcase
    end
    starts.push_back(pc);
    mem[pc] = 8'h76;
    // Forward targets only so the program always reaches HALT
    foreach (jump_at[j]) begin
      k = jump_ins[j];
      rand_bits(8, t);
      tgt = starts[k + 1 + (t % (starts.size() - k - 1))];
      mem[jump_at[j]] = 8'(tgt);
      mem[jump_at[j] + 1] = 8'(tgt >> 8);
    end
  endtask

  always @(negedge clk) begin
    if (reset) begin
      check("reset_mem_read", 0, mem_read);
      check("reset_mem_write", 0, mem_write);
      check("reset_halted", 0, halted);
    end else begin
      cycle++;
      check("bus_exclusive", 0, mem_read & mem_write);
      if (halted)
        check("strobe_after_halt", 0, mem_read | mem_write);
      if ((mem_read | mem_write) && !(prev_read | prev_write)) begin
        strobe_len  = 1;
        strobe_addr = addr_bus;
      end else if (mem_read | mem_write) begin
        strobe_len++;
        check("addr_stable", strobe_addr, addr_bus);
      end else if (prev_read | prev_write) begin
        check("strobe_length", 2, strobe_len);
      end
      if (next_fetch < 0 && mem_read && !prev_read) begin
        check("first_fetch_addr", 0, addr_bus);
        next_fetch = cycle;
      end
      if (next_fetch >= 0 && cycle == next_fetch) begin
        if (fetch_idx < exp_pc.size()) begin
          check("fetch_strobe", 1, mem_read && !prev_read);
          check("fetch_addr", exp_pc[fetch_idx], addr_bus);
          next_fetch = cycle + 4 * exp_cycles[fetch_idx];
          fetch_idx++;
        end else begin
          check("halt_after_last_fetch", 1, halted);  // No fetch past HALT
        end
      end
      if (mem_write && !prev_write) begin
        if (write_idx < exp_waddr.size()) begin
          check("write_addr", exp_waddr[write_idx], addr_bus);
          check("write_data", exp_wdata[write_idx], wdata);
        end else begin
          errors++;
          $display("Unexpected memory write to %h", addr_bus);
        end
        mem[addr_bus] = wdata;
        write_idx++;
      end
    end
    prev_read  = mem_read;
    prev_write = mem_write;
  end

  initial begin
    int limit;
    int waited;
    reset       = 1'b1;
    rdata       = 8'h00;
    errors      = 0;
    cycle       = 0;
    next_fetch  = -1;
    fetch_idx   = 0;
    write_idx   = 0;
    strobe_len  = 0;
    strobe_addr = 16'h0000;
    prev_read   = 1'b0;
    prev_write  = 1'b0;
    lfsr        = 16'd49;
    build_program();
    for (int i = 0; i < 65536; i++)
      mm[i] = mem[i];
    model_run();
    limit = 100;
    foreach (exp_cycles[i])
      limit += 4 * exp_cycles[i];

    repeat (5) @(posedge clk);
    reset <= 1'b0;

    waited = 0;
    while (!halted && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    if (!halted) begin
      errors++;
      $display("halted never rose within %0d cycles", limit);
    end else begin
      for (int i = 0; i < 12; i++)
        @(negedge clk);  // Watch for stray strobes
      check("fetch_count", exp_pc.size(), fetch_idx);
      check("write_count", exp_waddr.size(), write_idx);
      for (int a = 16'hC000; a < 16'hC200; a++)
        check("data_mem", mm[a], mem[a]);
    end

    $display("Errors: %0d", errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire
